//--- hw/udp_echo_core.sv
// Top level of the UDP echo core; connects the filter, payload FIFO and reply builder
`timescale 1ns/10ps

module udp_echo_core (
    input  logic                      clk_125mhz,
    input  logic                      rst_125mhz,

    input  udp_echo_pkg::udp_hdr_t    rx_hdr,
    input  logic                      rx_hdr_valid,
    output logic                      rx_hdr_ready,
    input  udp_echo_pkg::axis_beat_t  rx_payload,
    input  logic                      rx_payload_valid,
    output logic                      rx_payload_ready,

    output udp_echo_pkg::udp_hdr_t    tx_hdr,
    output logic                      tx_hdr_valid,
    input  logic                      tx_hdr_ready,
    output udp_echo_pkg::axis_beat_t  tx_payload,
    output logic                      tx_payload_valid,
    input  logic                      tx_payload_ready,

    output logic [7:0]                led
);

    // Filter to builder
    udp_echo_pkg::udp_hdr_t   fwd_hdr;
    logic                     fwd_hdr_valid;
    logic                     fwd_hdr_ready;

    // Filter to FIFO and FIFO to builder
    udp_echo_pkg::axis_beat_t wr_beat;
    logic                     wr_valid;
    logic                     wr_ready;
    udp_echo_pkg::axis_beat_t rd_beat;
    logic                     rd_valid;
    logic                     rd_ready;

    udp_rx_filter u_rx_filter (
        .clk_125mhz       (clk_125mhz),
        .rst_125mhz       (rst_125mhz),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .fwd_hdr          (fwd_hdr),
        .fwd_hdr_valid    (fwd_hdr_valid),
        .fwd_hdr_ready    (fwd_hdr_ready),
        .wr_beat          (wr_beat),
        .wr_valid         (wr_valid),
        .wr_ready         (wr_ready)
    );

    udp_payload_fifo u_payload_fifo (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .wr_beat    (wr_beat),
        .wr_valid   (wr_valid),
        .wr_ready   (wr_ready),
        .rd_beat    (rd_beat),
        .rd_valid   (rd_valid),
        .rd_ready   (rd_ready)
    );

    udp_reply_builder u_reply_builder (
        .clk_125mhz       (clk_125mhz),
        .rst_125mhz       (rst_125mhz),
        .fwd_hdr          (fwd_hdr),
        .fwd_hdr_valid    (fwd_hdr_valid),
        .fwd_hdr_ready    (fwd_hdr_ready),
        .rd_beat          (rd_beat),
        .rd_valid         (rd_valid),
        .rd_ready         (rd_ready),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .led              (led)
    );

endmodule

//--- hw/udp_echo_pkg.sv
// Shared header, payload beat and filter state types of the UDP echo core
package udp_echo_pkg;

    // UDP header as seen by the echo core, used for rx and reply headers
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
    } udp_hdr_t;

    // One payload byte with its stream flags
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } axis_beat_t;

    // Per-frame state of the receive filter
    typedef enum logic [1:0] {
        FILTER_IDLE    = 2'd0,
        FILTER_FORWARD = 2'd1,
        FILTER_DROP    = 2'd2
    } filter_state_e;

endpackage

//--- hw/udp_payload_fifo.sv
// Processing part of the echo core; RAM-based FIFO of payload beats between filter and builder
`timescale 1ns/10ps

`include "udp_echo_macros.svh"

module udp_payload_fifo #(
    parameter int ADDR_WIDTH = `UDP_FIFO_ADDR_WIDTH
) (
    input  logic                      clk_125mhz,
    input  logic                      rst_125mhz,

    input  udp_echo_pkg::axis_beat_t  wr_beat,
    input  logic                      wr_valid,
    output logic                      wr_ready,

    output udp_echo_pkg::axis_beat_t  rd_beat,
    output logic                      rd_valid,
    input  logic                      rd_ready
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    udp_echo_pkg::axis_beat_t mem [DEPTH];

    // Extra MSB tells full from empty
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign wr_ready = !full;
    assign rd_valid = !empty;
    assign wr_en    = wr_valid && wr_ready;
    assign rd_en    = rd_valid && rd_ready;

    // Head of queue read asynchronously, visible the cycle after the write
    assign rd_beat = mem[rd_ptr[ADDR_WIDTH-1:0]];

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_beat;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // A full FIFO holds its write pointer whatever the writer does
    a_no_write_when_full: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        (full && wr_valid) |=> (wr_ptr == $past(wr_ptr)));

endmodule

//--- hw/udp_reply_builder.sv
// Output side of the echo core; holds the reply header, presents the payload and drives the LEDs
`timescale 1ns/10ps

module udp_reply_builder (
    input  logic                      clk_125mhz,
    input  logic                      rst_125mhz,

    input  udp_echo_pkg::udp_hdr_t    fwd_hdr,
    input  logic                      fwd_hdr_valid,
    output logic                      fwd_hdr_ready,

    input  udp_echo_pkg::axis_beat_t  rd_beat,
    input  logic                      rd_valid,
    output logic                      rd_ready,

    output udp_echo_pkg::udp_hdr_t    tx_hdr,
    output logic                      tx_hdr_valid,
    input  logic                      tx_hdr_ready,

    output udp_echo_pkg::axis_beat_t  tx_payload,
    output logic                      tx_payload_valid,
    input  logic                      tx_payload_ready,

    output logic [7:0]                led
);

    udp_echo_pkg::udp_hdr_t hdr_reg;

    logic       hdr_valid_reg;
    logic       first_beat;
    logic [7:0] led_reg;
    logic       beat_xfer;

    // One-entry slot, refillable in the cycle it drains
    assign fwd_hdr_ready = !hdr_valid_reg || tx_hdr_ready;

    assign tx_hdr       = hdr_reg;
    assign tx_hdr_valid = hdr_valid_reg;

    always_ff @(posedge clk_125mhz) begin
        if (fwd_hdr_valid && fwd_hdr_ready) begin
            hdr_reg <= fwd_hdr;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            hdr_valid_reg <= 1'b0;
        end else if (fwd_hdr_valid && fwd_hdr_ready) begin
            hdr_valid_reg <= 1'b1;
        end else if (tx_hdr_ready) begin
            hdr_valid_reg <= 1'b0;
        end
    end

    // Payload passes straight from the FIFO
    assign tx_payload       = rd_beat;
    assign tx_payload_valid = rd_valid;
    assign rd_ready         = tx_payload_ready;

    assign beat_xfer = rd_valid && tx_payload_ready;
    assign led       = led_reg;

    // Latch first byte of each frame for the LEDs
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            first_beat <= 1'b1;
            led_reg    <= 8'd0;
        end else if (beat_xfer) begin
            if (first_beat) begin
                led_reg <= rd_beat.data;
            end
            first_beat <= rd_beat.last;
        end
    end

    // Reply header held steady while the sink stalls
    a_hdr_stable: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        (tx_hdr_valid && !tx_hdr_ready) |=> (tx_hdr_valid && $stable(tx_hdr)));

endmodule

//--- hw/udp_rx_filter.sv
// Input side of the echo core; matches the port, forms the reply header and steers payload
`timescale 1ns/10ps

`include "udp_echo_macros.svh"

module udp_rx_filter (
    input  logic                      clk_125mhz,
    input  logic                      rst_125mhz,

    input  udp_echo_pkg::udp_hdr_t    rx_hdr,
    input  logic                      rx_hdr_valid,
    output logic                      rx_hdr_ready,

    input  udp_echo_pkg::axis_beat_t  rx_payload,
    input  logic                      rx_payload_valid,
    output logic                      rx_payload_ready,

    output udp_echo_pkg::udp_hdr_t    fwd_hdr,
    output logic                      fwd_hdr_valid,
    input  logic                      fwd_hdr_ready,

    output udp_echo_pkg::axis_beat_t  wr_beat,
    output logic                      wr_valid,
    input  logic                      wr_ready
);

    udp_echo_pkg::filter_state_e state;

    logic hdr_match;
    logic hdr_xfer;
    logic payload_xfer;

    assign hdr_match = (rx_hdr.dst_port == `UDP_ECHO_PORT);

    // Reply header with ports swapped and the sender as destination
    assign fwd_hdr.src_ip   = `UDP_LOCAL_IP;
    assign fwd_hdr.dst_ip   = rx_hdr.src_ip;
    assign fwd_hdr.src_port = rx_hdr.dst_port;
    assign fwd_hdr.dst_port = rx_hdr.src_port;
    assign fwd_hdr.length   = rx_hdr.length;

    // Headers only taken between frames
    assign fwd_hdr_valid = rx_hdr_valid && hdr_match && (state == udp_echo_pkg::FILTER_IDLE);
    assign rx_hdr_ready  = (state == udp_echo_pkg::FILTER_IDLE) && (!hdr_match || fwd_hdr_ready);
    assign hdr_xfer      = rx_hdr_valid && rx_hdr_ready;

    // Dropped frames are sunk at full rate
    assign rx_payload_ready = (state == udp_echo_pkg::FILTER_DROP) ||
                              ((state == udp_echo_pkg::FILTER_FORWARD) && wr_ready);
    assign payload_xfer     = rx_payload_valid && rx_payload_ready;

    assign wr_beat  = rx_payload;
    assign wr_valid = rx_payload_valid && (state == udp_echo_pkg::FILTER_FORWARD);

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= udp_echo_pkg::FILTER_IDLE;
        end else begin
            case (state)
                udp_echo_pkg::FILTER_IDLE: begin
                    if (hdr_xfer) begin
                        state <= hdr_match ? udp_echo_pkg::FILTER_FORWARD
                                           : udp_echo_pkg::FILTER_DROP;
                    end
                end
                udp_echo_pkg::FILTER_FORWARD,
                udp_echo_pkg::FILTER_DROP: begin
                    // Frame ends with its last beat
                    if (payload_xfer && rx_payload.last) begin
                        state <= udp_echo_pkg::FILTER_IDLE;
                    end
                end
                default: begin
                    state <= udp_echo_pkg::FILTER_IDLE;
                end
            endcase
        end
    end

    // Payload only moves after its header was taken
    a_no_payload_in_idle: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        payload_xfer |-> (state != udp_echo_pkg::FILTER_IDLE));

endmodule

//--- include/udp_echo_macros.svh
// Echo core constants; include wherever the echo port, local IP or FIFO depth is needed
`ifndef UDP_ECHO_MACROS_SVH
`define UDP_ECHO_MACROS_SVH

// UDP destination port that gets answered
`define UDP_ECHO_PORT 16'd1234

// Local address 192.168.1.128, used as source IP of every reply
`define UDP_LOCAL_IP {8'd192, 8'd168, 8'd1, 8'd128}

// Default payload FIFO address width, 1024 beats
`define UDP_FIFO_ADDR_WIDTH 10

`endif

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module udp_echo_tb -f udp_echo_core.f \
    -o udp_echo_sim \
    && ./obj_dir/udp_echo_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- tests/udp_echo_tb.sv
// Directed testbench of the UDP echo core; compile with the file list and run udp_echo_tb as top
`timescale 1ns/10ps

module udp_echo_tb;

    localparam int TIMEOUT = 5000;

    logic                     clk_125mhz;
    logic                     rst_125mhz;
    udp_echo_pkg::udp_hdr_t   rx_hdr;
    logic                     rx_hdr_valid;
    logic                     rx_hdr_ready;
    udp_echo_pkg::axis_beat_t rx_payload;
    logic                     rx_payload_valid;
    logic                     rx_payload_ready;
    udp_echo_pkg::udp_hdr_t   tx_hdr;
    logic                     tx_hdr_valid;
    logic                     tx_hdr_ready;
    udp_echo_pkg::axis_beat_t tx_payload;
    logic                     tx_payload_valid;
    logic                     tx_payload_ready;
    logic [7:0]               led;

    int                       stim_seed;
    int                       ready_seed;
    int                       value_errors;
    int                       timeouts;
    logic                     rand_ready;
    logic                     hdr_held;
    logic [7:0]               exp_led;
    udp_echo_pkg::udp_hdr_t   held_hdr;
    udp_echo_pkg::udp_hdr_t   exp_hdr[$];
    udp_echo_pkg::axis_beat_t exp_beat[$];

    udp_echo_core u_dut (.*);

    initial begin
        clk_125mhz = 1'b0;
        forever #4 clk_125mhz = ~clk_125mhz;
    end

    function automatic logic rand_bit(inout int s);
        logic [31:0] r;
        r = $random(s);
        return r[0];
    endfunction

    // Reply header as the echo rules define it
    function automatic udp_echo_pkg::udp_hdr_t reply_of(input udp_echo_pkg::udp_hdr_t h);
        udp_echo_pkg::udp_hdr_t r;
        r.src_ip   = 32'hc0a8_0180;
        r.dst_ip   = h.src_ip;
        r.src_port = h.dst_port;
        r.dst_port = h.src_port;
        r.length   = h.length;
        return r;
    endfunction

    task automatic check_hdr(input string name, input udp_echo_pkg::udp_hdr_t got,
                             input udp_echo_pkg::udp_hdr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_beat(input string name, input udp_echo_pkg::axis_beat_t got,
                              input udp_echo_pkg::axis_beat_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_led(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Every tx transfer is matched against the expected queues
    always @(posedge clk_125mhz) begin
        if (!rst_125mhz) begin
            if (hdr_held) check_hdr("tx_hdr while stalled", tx_hdr, held_hdr);
            hdr_held = tx_hdr_valid && !tx_hdr_ready;
            held_hdr = tx_hdr;
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr.size() == 0) begin
                    value_errors++;
                    $display("Reply header sent at %0t with no frame to answer", $time);
                end else begin
                    check_hdr("tx_hdr", tx_hdr, exp_hdr.pop_front());
                end
            end
            if (tx_payload_valid && tx_payload_ready) begin
                if (exp_beat.size() == 0) begin
                    value_errors++;
                    $display("Payload byte sent at %0t with none expected", $time);
                end else begin
                    check_beat("tx_payload", tx_payload, exp_beat.pop_front());
                end
            end
        end
    end

    // Random sink stalls
    always @(negedge clk_125mhz) begin
        if (rand_ready) begin
            tx_hdr_ready     = rand_bit(ready_seed);
            tx_payload_ready = rand_bit(ready_seed);
        end
    end

    task automatic send_hdr(input udp_echo_pkg::udp_hdr_t h);
        int n;
        @(negedge clk_125mhz);
        rx_hdr       = h;
        rx_hdr_valid = 1'b1;
        n = 0;
        do begin
            @(posedge clk_125mhz);
            n++;
        end while (!rx_hdr_ready && n < TIMEOUT);
        if (!rx_hdr_ready) begin
            timeouts++;
            $display("Timeout at %0t: rx header was never accepted", $time);
        end
        @(negedge clk_125mhz);
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_payload(input udp_echo_pkg::axis_beat_t b);
        int n;
        @(negedge clk_125mhz);
        rx_payload       = b;
        rx_payload_valid = 1'b1;
        n = 0;
        do begin
            @(posedge clk_125mhz);
            n++;
        end while (!rx_payload_ready && n < TIMEOUT);
        if (!rx_payload_ready) begin
            timeouts++;
            $display("Timeout at %0t: rx payload byte was never accepted", $time);
        end
    endtask

    // Beat number stall_at waits for a full FIFO and then frees the tx payload side
    task automatic send_frame(input logic match, input int len, input int stall_at);
        udp_echo_pkg::udp_hdr_t   h;
        udp_echo_pkg::axis_beat_t b;
        int                       n;
        h.src_ip   = $random(stim_seed);
        h.dst_ip   = 32'hc0a8_0180;
        h.src_port = 16'($random(stim_seed));
        h.dst_port = match ? 16'd1234 : 16'd1235 + 16'($random(stim_seed) & 32'hff);
        h.length   = 16'(len + 8);
        if (match) exp_hdr.push_back(reply_of(h));
        send_hdr(h);
        for (int i = 0; i < len; i++) begin
            b.data = 8'($random(stim_seed));
            b.last = (i == len - 1);
            b.user = rand_bit(stim_seed);
            if (match) exp_beat.push_back(b);
            if (match && i == 0) exp_led = b.data;
            if (i == stall_at) begin
                @(negedge clk_125mhz);
                rx_payload       = b;
                rx_payload_valid = 1'b1;
                n = 0;
                do begin
                    @(posedge clk_125mhz);
                    n++;
                end while (rx_payload_ready && n < TIMEOUT);
                if (rx_payload_ready) begin
                    timeouts++;
                    $display("Timeout at %0t: rx_payload_ready stayed high with the FIFO full",
                             $time);
                end
                @(negedge clk_125mhz);
                tx_payload_ready = 1'b1;
            end
            send_payload(b);
        end
        @(negedge clk_125mhz);
        rx_payload_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_hdr.size() != 0 || exp_beat.size() != 0) && n < TIMEOUT) begin
            @(posedge clk_125mhz);
            n++;
        end
        if (exp_hdr.size() != 0 || exp_beat.size() != 0) begin
            timeouts++;
            $display("Timeout at %0t: %0d reply headers and %0d payload bytes never came out",
                     $time, exp_hdr.size(), exp_beat.size());
        end
        @(negedge clk_125mhz);
        check_led("led", led, exp_led);
    endtask

    task automatic test_echo();
        send_frame(1'b1, 16, -1);
        send_frame(1'b1, 1, -1);
        wait_drain();
    endtask

    // Quiet window after a dropped frame, the monitor flags any tx activity
    task automatic test_drop();
        send_frame(1'b0, 12, -1);
        repeat (100) @(posedge clk_125mhz);
        check_led("led after dropped frame", led, exp_led);
        send_frame(1'b1, 9, -1);
        wait_drain();
    endtask

    task automatic test_random_ready();
        rand_ready = 1'b1;
        repeat (3) send_frame(1'b1, 20, -1);
        send_frame(1'b0, 5, -1);
        send_frame(1'b1, 7, -1);
        wait_drain();
        rand_ready = 1'b0;
        @(negedge clk_125mhz);
        tx_hdr_ready     = 1'b1;
        tx_payload_ready = 1'b1;
    endtask

    task automatic test_fifo_full();
        @(negedge clk_125mhz);
        tx_payload_ready = 1'b0;
        send_frame(1'b1, 1100, 1024);
        wait_drain();
        repeat (4) send_frame(1'b1, 3, -1);
        wait_drain();
    endtask

    initial begin
        stim_seed        = 32'h02dd_8cab;
        ready_seed       = 32'h02dd_8cab;
        value_errors     = 0;
        timeouts         = 0;
        rand_ready       = 1'b0;
        hdr_held         = 1'b0;
        exp_led          = 8'd0;
        rst_125mhz       = 1'b1;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        tx_hdr_ready     = 1'b1;
        tx_payload_ready = 1'b1;
        repeat (5) @(posedge clk_125mhz);
        @(negedge clk_125mhz);
        rst_125mhz = 1'b0;
        check_led("led after reset", led, 8'd0);
        test_echo();
        test_drop();
        test_random_ready();
        test_fifo_full();
        $display("Run complete: %0d value errors, %0d timeouts", value_errors, timeouts);
        if (value_errors + timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- udp_echo_core.f
+incdir+include
hw/udp_echo_pkg.sv
hw/udp_rx_filter.sv
hw/udp_payload_fifo.sv
hw/udp_reply_builder.sv
hw/udp_echo_core.sv
tests/udp_echo_tb.sv
